//--- hdl/sms_cart_pkg.sv
// Shared widths, constants and bus structs for the cartridge host
// Imported by every RTL block that touches the download bus or the ROM path
`default_nettype none

package sms_cart_pkg;

	// ========================================
	// Sizes and fixed values
	// ========================================
	localparam int rom_addr_w_default = 22;         // Full cartridge address space
	localparam int header_bytes       = 512;        // Optional image header
	localparam logic [7:0] code_index = 8'hFF;      // Download index of cheat codes
	localparam logic [4:0] gg_index   = 5'd2;       // Low index bits of a Game Gear image

	// Clock enable sequencer
	localparam int ce_div        = 30;
	localparam int ce_vdp_period = 5;
	localparam int ce_pix_period = 10;
	localparam int ce_cpu_phase_a = 9;              // Coincides with a pixel enable
	localparam int ce_cpu_phase_b = 24;

	// ========================================
	// Bundles
	// ========================================
	typedef struct packed {
		logic        wr;        // One-cycle byte strobe
		logic        download;  // High for a whole transfer
		logic [7:0]  index;
		logic [15:0] addr;
		logic [7:0]  dout;
	} dl_bus_t;

	// One cheat, each field little endian
	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] address;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

	typedef struct packed {
		logic cpu;
		logic vdp;
		logic pix;
		logic sp;
	} clk_en_t;

	typedef struct packed {
		logic [21:0] addr;
		logic [7:0]  data;
	} rom_wr_t;

	typedef struct packed {
		logic [21:0] mask;      // Plain image mirror mask
		logic [21:0] mask512;   // Mask of the image behind a header
		logic        sz512;     // Header present
	} cart_geom_t;

endpackage

`default_nettype wire

//--- hdl/clock_enable_gen.sv
// Divide-by-30 sequencer for the CPU, VDP, pixel and sound clock enables
// Free running from reset release, all enables one clk_sys cycle wide
`default_nettype none

module clock_enable_gen (
	input  logic                  clk_sys,
	input  logic                  arst_n,
	output sms_cart_pkg::clk_en_t ce
);
	import sms_cart_pkg::*;

	localparam int cnt_w = $clog2(ce_div);

	logic [cnt_w-1:0] cnt;
	logic             hit_vdp;
	logic             hit_pix;
	logic             hit_cpu;

	// Phase decode on the current count, registered below
	assign hit_vdp = (cnt % ce_vdp_period) == (ce_vdp_period - 1);
	assign hit_pix = (cnt % ce_pix_period) == (ce_pix_period - 1);
	assign hit_cpu = (cnt == cnt_w'(ce_cpu_phase_a)) || (cnt == cnt_w'(ce_cpu_phase_b));

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			cnt <= '0;
		end else if (cnt == cnt_w'(ce_div - 1)) begin
			cnt <= '0;
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

	// Sound enable toggles; even sequence length keeps it regular across the wrap
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			ce <= '0;
		end else begin
			ce.sp  <= cnt[0];
			ce.vdp <= hit_vdp;
			ce.pix <= hit_pix;
			ce.cpu <= hit_cpu;  // Two per sequence, 15 apart
		end
	end

endmodule

`default_nettype wire

//--- hdl/cart_loader.sv
// Turns cartridge download bytes into ROM write requests and holds the host off
// Also learns the mirror masks, the header flag and the Game Gear flag
`default_nettype none

module cart_loader #(
	parameter int rom_addr_w = sms_cart_pkg::rom_addr_w_default
) (
	input  logic                     clk_sys,
	input  logic                     arst_n,
	input  sms_cart_pkg::dl_bus_t    dl,
	output logic                     ioctl_wait,
	output logic                     wr_req,
	output sms_cart_pkg::rom_wr_t    wr,
	input  logic                     wr_ack,
	output sms_cart_pkg::cart_geom_t geom,
	output logic                     gg
);
	import sms_cart_pkg::*;

	localparam int hdr_bit = $clog2(header_bytes);  // Byte count bit marking a header

	logic                  cart_dl;
	logic                  cart_wr;
	logic                  cart_dl_q;
	logic [rom_addr_w-1:0] wr_addr;
	logic [7:0]            wr_data;
	logic [21:0]           dl_addr;

	assign cart_dl = dl.download && (dl.index != code_index);
	assign cart_wr = cart_dl && dl.wr;
	assign dl_addr = 22'(dl.addr);
	assign wr      = '{addr: 22'(wr_addr), data: wr_data};

	// ========================================
	// Write sequencing
	// ========================================
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			cart_dl_q  <= 1'b0;
			ioctl_wait <= 1'b0;
			wr_req     <= 1'b0;
			wr_addr    <= '0;
		end else begin
			cart_dl_q <= cart_dl;
			if (cart_wr) begin
				ioctl_wait <= 1'b1;
				wr_req     <= 1'b1;
			end else if (wr_ack) begin
				ioctl_wait <= 1'b0;  // Host may send the next byte
				wr_req     <= 1'b0;
			end
			if (cart_dl && !cart_dl_q) begin
				wr_addr <= '0;  // New image starts at the bottom
			end else if (wr_ack) begin
				wr_addr <= wr_addr + 1'b1;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (cart_wr) begin
			wr_data <= dl.dout;
		end
	end

	// ========================================
	// Image geometry
	// ========================================
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			geom <= '0;
			gg   <= 1'b0;
		end else begin
			if (cart_wr) begin
				geom.mask <= (dl_addr == '0) ? '0 : (geom.mask | dl_addr);
				// Offsets behind the header
				if (dl_addr == 22'(header_bytes)) begin
					geom.mask512 <= '0;
				end else if (dl_addr > 22'(header_bytes)) begin
					geom.mask512 <= geom.mask512 | (dl_addr - 22'(header_bytes));
				end
				gg <= (dl.index[4:0] == gg_index);
			end
			// Odd multiple of 512 bytes means a header in front
			if (cart_dl_q && !cart_dl) begin
				geom.sz512 <= wr_addr[hdr_bit];
			end
		end
	end

endmodule

`default_nettype wire

//--- hdl/cheat_code_loader.sv
// Collects sixteen cheat bytes from the download bus into one cheat record
// code_valid pulses once the last byte of a record has landed
`default_nettype none

module cheat_code_loader (
	input  logic                      clk_sys,
	input  logic                      arst_n,
	input  sms_cart_pkg::dl_bus_t     dl,
	output sms_cart_pkg::cheat_code_t code,
	output logic                      code_valid
);
	import sms_cart_pkg::*;

	logic       code_wr;
	logic [1:0] byte_sel;   // Byte within a field
	logic [1:0] field_sel;  // Flags, address, compare, replace

	assign code_wr   = dl.wr && dl.download && (dl.index == code_index);
	assign byte_sel  = dl.addr[1:0];
	assign field_sel = dl.addr[3:2];

	// ========================================
	// Byte placement
	// ========================================
	always_ff @(posedge clk_sys) begin
		if (code_wr) begin
			case (field_sel)
				2'd0: code.flags[8*byte_sel +: 8]   <= dl.dout;
				2'd1: code.address[8*byte_sel +: 8] <= dl.dout;
				2'd2: code.compare[8*byte_sel +: 8] <= dl.dout;
				default: begin
					code.replace[8*byte_sel +: 8] <= dl.dout;
				end
			endcase
		end
	end

	// Last byte completes the record
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			code_valid <= 1'b0;
		end else begin
			code_valid <= code_wr && (dl.addr[3:0] == 4'hF);
		end
	end

endmodule

`default_nettype wire

//--- hdl/rom_arbiter.sv
// Shares the ROM store between loader writes and translated console reads
// Writes win; a read blocked by a write waits in a one-entry slot
`default_nettype none

module rom_arbiter #(
	parameter int rom_addr_w = sms_cart_pkg::rom_addr_w_default
) (
	input  logic                     clk_sys,
	input  logic                     arst_n,
	input  logic                     wr_req,
	input  sms_cart_pkg::rom_wr_t    wr,
	output logic                     wr_ack,
	input  sms_cart_pkg::cart_geom_t geom,
	input  logic                     rom_rd,
	input  logic [rom_addr_w-1:0]    rom_a,
	output logic [7:0]               rom_do,
	output logic                     rom_valid,
	output logic [rom_addr_w-1:0]    mem_addr,
	output logic                     mem_we,
	output logic [7:0]               mem_d,
	input  logic [7:0]               mem_q
);
	import sms_cart_pkg::*;

	logic                  wr_grant;
	logic                  rd_any;
	logic                  rd_pend;   // Read waiting behind a write
	logic                  rd_issue;  // Read address on the store this cycle
	logic [rom_addr_w-1:0] pend_a;
	logic [rom_addr_w-1:0] rd_a;
	logic [rom_addr_w-1:0] xlat;

	assign wr_grant = wr_req && !wr_ack;  // One grant per request
	assign rd_any   = rd_pend || rom_rd;
	assign rom_do   = mem_q;

	// Mirror through the learned masks, skipping a header when present
	always_comb begin
		rd_a = rd_pend ? pend_a : rom_a;
		if (geom.sz512) begin
			xlat = (rd_a & geom.mask512[rom_addr_w-1:0]) + rom_addr_w'(header_bytes);
		end else begin
			xlat = rd_a & geom.mask[rom_addr_w-1:0];
		end
	end

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			wr_ack    <= 1'b0;
			mem_we    <= 1'b0;
			rd_pend   <= 1'b0;
			rd_issue  <= 1'b0;
			rom_valid <= 1'b0;
		end else begin
			wr_ack    <= wr_grant;
			mem_we    <= wr_grant;
			rd_issue  <= !wr_grant && rd_any;
			rom_valid <= rd_issue;  // Store data is out one cycle after issue
			rd_pend   <= wr_grant && rd_any;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (rom_rd) begin
			pend_a <= rom_a;
		end
		if (wr_grant) begin
			mem_addr <= wr.addr[rom_addr_w-1:0];
			mem_d    <= wr.data;
		end else if (rd_any) begin
			mem_addr <= xlat;
		end
	end

endmodule

`default_nettype wire

//--- hdl/rom_store.sv
// Single-port byte memory that holds the downloaded cartridge image
// Read data appears the cycle after the address
`default_nettype none

module rom_store #(
	parameter int rom_addr_w = 22
) (
	input  logic                  clk_sys,
	input  logic [rom_addr_w-1:0] addr,
	input  logic                  we,
	input  logic [7:0]            d,
	output logic [7:0]            q
);

	logic [7:0] mem [2**rom_addr_w];

	always_ff @(posedge clk_sys) begin
		if (we) begin
			mem[addr] <= d;
		end
		q <= mem[addr];  // Old data on a write cycle
	end

endmodule

`default_nettype wire

//--- hdl/sms_cart_host.sv
// Cartridge side of the console host: clock enables, downloads and ROM reads
// rom_addr_w sets the depth of the ROM store and of the read port
`default_nettype none

module sms_cart_host #(
	parameter int rom_addr_w = sms_cart_pkg::rom_addr_w_default
) (
	input  logic                      clk_sys,
	input  logic                      arst_n,
	input  sms_cart_pkg::dl_bus_t     dl,
	output logic                      ioctl_wait,
	input  logic                      rom_rd,
	input  logic [rom_addr_w-1:0]     rom_a,
	output logic [7:0]                rom_do,
	output logic                      rom_valid,
	output sms_cart_pkg::cheat_code_t code,
	output logic                      code_valid,
	output logic                      gg,
	output sms_cart_pkg::clk_en_t     ce
);
	import sms_cart_pkg::*;

	logic                  wr_req;
	rom_wr_t               wr;
	logic                  wr_ack;
	cart_geom_t            geom;
	logic [rom_addr_w-1:0] mem_addr;
	logic                  mem_we;
	logic [7:0]            mem_d;
	logic [7:0]            mem_q;

	clock_enable_gen clock_enable_gen_inst (
		.clk_sys (clk_sys),
		.arst_n  (arst_n),
		.ce      (ce)
	);

	cart_loader #(.rom_addr_w(rom_addr_w)) cart_loader_inst (
		.clk_sys    (clk_sys),
		.arst_n     (arst_n),
		.dl         (dl),
		.ioctl_wait (ioctl_wait),
		.wr_req     (wr_req),
		.wr         (wr),
		.wr_ack     (wr_ack),
		.geom       (geom),
		.gg         (gg)
	);

	cheat_code_loader cheat_code_loader_inst (
		.clk_sys    (clk_sys),
		.arst_n     (arst_n),
		.dl         (dl),
		.code       (code),
		.code_valid (code_valid)
	);

	// ROM path
	rom_arbiter #(.rom_addr_w(rom_addr_w)) rom_arbiter_inst (
		.clk_sys   (clk_sys),
		.arst_n    (arst_n),
		.wr_req    (wr_req),
		.wr        (wr),
		.wr_ack    (wr_ack),
		.geom      (geom),
		.rom_rd    (rom_rd),
		.rom_a     (rom_a),
		.rom_do    (rom_do),
		.rom_valid (rom_valid),
		.mem_addr  (mem_addr),
		.mem_we    (mem_we),
		.mem_d     (mem_d),
		.mem_q     (mem_q)
	);

	rom_store #(.rom_addr_w(rom_addr_w)) rom_store_inst (
		.clk_sys (clk_sys),
		.addr    (mem_addr),
		.we      (mem_we),
		.d       (mem_d),
		.q       (mem_q)
	);

endmodule

`default_nettype wire

//--- verif/sms_cart_host_props.sv
// Handshake assertions for the cartridge host, bound onto the top level
`default_nettype none

module sms_cart_host_props (
	input logic                  clk_sys,
	input logic                  arst_n,
	input sms_cart_pkg::dl_bus_t dl,
	input logic                  ioctl_wait,
	input logic                  code_valid,
	input sms_cart_pkg::clk_en_t ce,
	input logic                  rom_rd,
	input logic                  rom_valid
);
	timeunit 1ns;
	timeprecision 1ps;

	logic rd_open;  // Read accepted, data not yet returned

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			rd_open <= 1'b0;
		end else if (rom_rd) begin
			rd_open <= 1'b1;
		end else if (rom_valid) begin
			rd_open <= 1'b0;
		end
	end

	no_wr_in_wait: assert property (@(posedge clk_sys) disable iff (!arst_n)
		!(dl.wr && ioctl_wait))
		else $error("Download strobe while ioctl_wait is high");

	code_valid_pulse: assert property (@(posedge clk_sys) disable iff (!arst_n)
		code_valid |=> !code_valid)
		else $error("code_valid held longer than one cycle");

	pix_on_vdp: assert property (@(posedge clk_sys) disable iff (!arst_n)
		ce.pix |-> ce.vdp)
		else $error("Pixel enable without a VDP enable");

	valid_after_rd: assert property (@(posedge clk_sys) disable iff (!arst_n)
		rom_valid |-> rd_open)
		else $error("rom_valid without an outstanding rom_rd");

endmodule

bind sms_cart_host sms_cart_host_props sms_cart_host_props_inst (
	.clk_sys    (clk_sys),
	.arst_n     (arst_n),
	.dl         (dl),
	.ioctl_wait (ioctl_wait),
	.code_valid (code_valid),
	.ce         (ce),
	.rom_rd     (rom_rd),
	.rom_valid  (rom_valid)
);

`default_nettype wire

//--- verif/sms_cart_host_tb.sv
// Testbench for the cartridge host: clock enables, downloads, cheat codes and reads
// Stand-alone top, ends with a single pass or fail line
`default_nettype none

module sms_cart_host_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import sms_cart_pkg::*;

	localparam int rom_addr_w = 12;
	localparam int wait_limit = 50;  // Cycles allowed for any single wait

	logic                  clk_sys;
	logic                  arst_n;
	dl_bus_t               dl;
	logic                  ioctl_wait;
	logic                  rom_rd;
	logic [rom_addr_w-1:0] rom_a;
	logic [7:0]            rom_do;
	logic                  rom_valid;
	cheat_code_t           code;
	logic                  code_valid;
	logic                  gg;
	clk_en_t               ce;

	int         seed;
	logic [7:0] img [2048];   // Last cartridge image sent
	int         img_len;      // Its byte count
	logic [7:0] exp_q [$];    // Expected read data, oldest first
	int         code_pulses;

	sms_cart_host #(.rom_addr_w(rom_addr_w)) sms_cart_host_inst (
		.clk_sys    (clk_sys),
		.arst_n     (arst_n),
		.dl         (dl),
		.ioctl_wait (ioctl_wait),
		.rom_rd     (rom_rd),
		.rom_a      (rom_a),
		.rom_do     (rom_do),
		.rom_valid  (rom_valid),
		.code       (code),
		.code_valid (code_valid),
		.gg         (gg),
		.ce         (ce)
	);

	always #10 clk_sys = ~clk_sys;

	// ========================================
	// Reporting and compare tasks
	// ========================================
	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Result: FAILED");
		$fatal(1, "Stopping at the first error");
	endtask

	task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			abort_run($sformatf("Fail at %0t: %s is %h, expected %h", $time, name, got, exp));
		end
	endtask

	task automatic check_code(input string name, input cheat_code_t got, input cheat_code_t exp);
		if (got !== exp) begin
			abort_run($sformatf("Fail at %0t: %s is %h, expected %h", $time, name, got, exp));
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			abort_run($sformatf("Fail at %0t: %s is %b, expected %b", $time, name, got, exp));
		end
	endtask

	task automatic check_gap(input string name, input int got, input int exp);
		if (got != exp) begin
			abort_run($sformatf("Fail at %0t: %s is %0d, expected %0d", $time, name, got, exp));
		end
	endtask

	// ========================================
	// Reference model
	// ========================================
	// Smallest all-ones value not below top
	function automatic int ones_cover(input int top);
		int m;
		m = 0;
		while (m < top) begin
			m = (m << 1) | 1;
		end
		return m;
	endfunction

	function automatic logic [7:0] expected_byte(input int addr);
		int mask;
		int mask512;
		bit hdr;
		int loc;
		mask    = ones_cover(img_len - 1);  // OR over all written addresses
		mask512 = (img_len > 513) ? ones_cover(img_len - 513) : 0;
		hdr     = (img_len % 512 == 0) && ((img_len / 512) % 2 == 1);
		loc     = hdr ? (512 + (addr & mask512)) : (addr & mask);  // Game data after header
		return img[loc & 2047];
	endfunction

	// Every returned byte is matched against the oldest outstanding read
	always @(posedge clk_sys) begin
		if (arst_n === 1'b1 && rom_valid === 1'b1) begin
			if (exp_q.size() == 0) begin
				abort_run("rom_valid pulsed with no read outstanding");
			end else begin
				check_byte("rom_do", rom_do, exp_q.pop_front());
			end
		end
	end

	always @(posedge clk_sys) begin
		if (code_valid === 1'b1) begin
			code_pulses <= code_pulses + 1;
		end
	end

	// ========================================
	// Stimulus tasks
	// ========================================
	task automatic wait_ioctl(input logic level);
		int n;
		n = 0;
		while (ioctl_wait !== level) begin
			if (n == wait_limit) begin
				abort_run($sformatf("Timeout waiting for ioctl_wait to reach %b", level));
			end
			@(posedge clk_sys);
			n++;
		end
	endtask

	task automatic send_cart(input logic [7:0] index, input int len, input logic exp_gg);
		int i;
		for (i = 0; i < len; i++) begin
			img[i] = 8'($random(seed));
		end
		img_len = len;
		dl.download <= 1'b1;
		dl.index    <= index;
		@(posedge clk_sys);
		for (i = 0; i < len; i++) begin
			dl.wr   <= 1'b1;
			dl.addr <= 16'(i);
			dl.dout <= img[i];
			@(posedge clk_sys);
			dl.wr <= 1'b0;
			wait_ioctl(1'b1);
			wait_ioctl(1'b0);  // Host holds off until the store took it
			check_bit("gg", gg, exp_gg);
		end
		dl.download <= 1'b0;
		repeat (4) @(posedge clk_sys);
	endtask

	task automatic read_check(input int addr);
		int n;
		exp_q.push_back(expected_byte(addr));
		rom_rd <= 1'b1;
		rom_a  <= rom_addr_w'(addr);
		@(posedge clk_sys);
		rom_rd <= 1'b0;
		n = 0;
		while (rom_valid !== 1'b1) begin
			if (n == wait_limit) begin
				abort_run($sformatf("Timeout waiting for rom_valid, address %0d", addr));
			end
			@(posedge clk_sys);
			n++;
		end
	endtask

	task automatic send_codes();
		int          i;
		int          n;
		logic [7:0]  b;
		cheat_code_t exp;
		exp = '0;
		dl.download <= 1'b1;
		dl.index    <= 8'hFF;
		@(posedge clk_sys);
		for (i = 0; i < 16; i++) begin
			b = 8'($random(seed));
			exp[(3 - i / 4) * 32 + 8 * (i % 4) +: 8] = b;  // Flags field sits on top
			dl.wr   <= 1'b1;
			dl.addr <= 16'(i);
			dl.dout <= b;
			@(posedge clk_sys);
			dl.wr <= 1'b0;
			@(posedge clk_sys);
			check_bit("ioctl_wait", ioctl_wait, 1'b0);
		end
		n = 0;
		while (code_valid !== 1'b1) begin
			if (n == wait_limit) begin
				abort_run("Timeout waiting for code_valid");
			end
			@(posedge clk_sys);
			n++;
		end
		check_code("code", code, exp);
		dl.download <= 1'b0;
		repeat (4) @(posedge clk_sys);
		check_byte("code_valid pulses", 8'(code_pulses), 8'd1);
	endtask

	task automatic check_enables();
		int cyc;
		int last_vdp;
		int last_pix;
		int last_sp;
		int last_cpu;
		int first_cpu;
		last_vdp  = -1;
		last_pix  = -1;
		last_sp   = -1;
		last_cpu  = -1;
		first_cpu = -1;
		for (cyc = 0; cyc < 60; cyc++) begin
			@(posedge clk_sys);
			if (ce.vdp) begin
				if (last_vdp >= 0) check_gap("ce.vdp spacing", cyc - last_vdp, 5);
				last_vdp = cyc;
			end
			if (ce.pix) begin
				if (last_pix >= 0) check_gap("ce.pix spacing", cyc - last_pix, 10);
				last_pix = cyc;
			end
			if (ce.sp) begin
				if (last_sp >= 0) check_gap("ce.sp spacing", cyc - last_sp, 2);
				last_sp = cyc;
			end
			if (ce.cpu) begin
				if (first_cpu < 0) first_cpu = cyc;
				else check_gap("ce.cpu spacing", cyc - last_cpu, 15);
				// Only every other CPU enable lands on a pixel enable
				check_bit("ce.pix with ce.cpu", ce.pix, ((cyc - first_cpu) % 30) == 0);
				last_cpu = cyc;
			end
		end
		check_bit("ce.vdp seen", last_vdp >= 0, 1'b1);
		check_bit("ce.pix seen", last_pix >= 0, 1'b1);
		check_bit("ce.sp seen", last_sp >= 0, 1'b1);
		check_bit("ce.cpu seen", last_cpu >= 0, 1'b1);
	endtask

	// ========================================
	// Test sequence
	// ========================================
	initial begin
		int a;
		seed        = 32'h2586_97ac;
		clk_sys     = 1'b0;
		arst_n      = 1'b0;
		dl          = '0;
		rom_rd      = 1'b0;
		rom_a       = '0;
		img_len     = 1;
		code_pulses = 0;
		repeat (10) @(posedge clk_sys);
		check_bit("ioctl_wait", ioctl_wait, 1'b0);
		check_bit("gg", gg, 1'b0);
		check_bit("code_valid", code_valid, 1'b0);
		check_bit("rom_valid", rom_valid, 1'b0);
		check_byte("ce", 8'(ce), 8'h00);
		arst_n <= 1'b1;

		check_enables();

		send_cart(8'h01, 1024, 1'b0);  // Plain image, mirrored above 1023
		for (a = 0; a < 2048; a++) begin
			read_check(a);
		end

		send_cart(8'h02, 1536, 1'b1);  // Game Gear image behind a header
		check_bit("gg", gg, 1'b1);
		for (a = 0; a < 2048; a++) begin
			read_check(a);
		end

		send_codes();
		for (a = 0; a < 256; a++) begin
			read_check(a * 7);
		end

		repeat (5) @(posedge clk_sys);
		if (exp_q.size() != 0) begin
			abort_run("Reads left without a rom_valid");
		end else begin
			$display("Result: PASSED");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- sms_cart_host.f
hdl/sms_cart_pkg.sv
hdl/clock_enable_gen.sv
hdl/cart_loader.sv
hdl/cheat_code_loader.sv
hdl/rom_arbiter.sv
hdl/rom_store.sv
hdl/sms_cart_host.sv
verif/sms_cart_host_props.sv
verif/sms_cart_host_tb.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --timing --assert -Wno-fatal
TOP       ?= sms_cart_host_tb
FILELIST  ?= sms_cart_host.f
OBJ_DIR   ?= obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# Passes only when the run prints the pass line
sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "Result: PASSED"

clean:
	rm -rf $(OBJ_DIR)
